//--- common/pio_pkg.sv
`default_nettype none

package pio_pkg;

  localparam int IMEM_DEPTH = 32;

  typedef logic [31:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  addr_t;
  typedef logic [4:0]  pin_t;
  typedef logic [2:0]  count_t;
  typedef logic [15:0] div_t;    // 0 ticks every cycle
  typedef logic [1:0]  sm_idx_t;

  // Instruction bits 15..13
  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,  // Bit 7 selects PULL
    OP_SET      = 3'd7
  } opcode_t;

  // Operand selector in bits 7..5
  localparam logic [2:0] JMP_ALWAYS  = 3'd0;
  localparam logic [2:0] JMP_X_ZERO  = 3'd1;
  localparam logic [2:0] JMP_X_DEC   = 3'd2;
  localparam logic [2:0] IN_SRC_PINS = 3'd0;
  localparam logic [2:0] SET_PINS    = 3'd0;
  localparam logic [2:0] SET_X       = 3'd1;
  localparam logic [2:0] SET_PINDIRS = 3'd4;

  typedef enum logic [3:0] {
    ACT_NOP         = 4'd0,
    ACT_WRITE_INSTR = 4'd1,
    ACT_SET_WRAP    = 4'd2,
    ACT_RX_POP      = 4'd3,
    ACT_TX_PUSH     = 4'd4,
    ACT_PIN_CONFIG  = 4'd5,
    ACT_ENABLE      = 4'd6,
    ACT_CLKDIV      = 4'd7,
    ACT_EXEC        = 4'd9
  } action_t;

  typedef struct packed {
    addr_t  wrap_bottom;
    addr_t  wrap_top;
    pin_t   out_base;
    count_t out_count;
    pin_t   set_base;
    count_t set_count;
    pin_t   in_base;
    div_t   clk_div;
  } sm_config_t;

  typedef struct packed {
    word_t values;
    word_t dirs;
    word_t owned;  // Pins inside OUT or SET window
  } sm_pins_t;

endpackage

`default_nettype wire

//--- pio/pio_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pio_fifo import pio_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        push,
  input  wire        pop,
  input  wire word_t wdata,
  output word_t      rdata,
  output logic       full,
  output logic       empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  word_t          mem [DEPTH];
  logic [PW-1:0]  wr_ptr, rd_ptr;
  logic [CW-1:0]  count;
  logic           do_push, do_pop;

  assign full    = count == CW'(DEPTH);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];  // Fall-through head

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- pio/pio_machine.sv
`timescale 1ns/1ps
`default_nettype none

module pio_machine import pio_pkg::*; (
  input  wire             clk,
  input  wire             reset,
  input  wire             en,
  input  wire             exec,
  input  wire instr_t     exec_instr,
  input  wire instr_t     instr,
  input  wire sm_config_t cfg,
  input  wire word_t      gpio_in,
  input  wire word_t      tx_data,
  input  wire             tx_empty,
  input  wire             rx_full,
  output addr_t           pc,
  output logic            tx_pop,
  output logic            rx_push,
  output word_t           rx_data,
  output sm_pins_t        pins
);

  localparam logic [5:0] FULL_COUNT = 6'd32;

  function automatic word_t low_mask(input logic [5:0] n);
    logic [63:0] m;
    m = (64'd1 << n) - 64'd1;
    return m[31:0];
  endfunction

  function automatic word_t rotl(input word_t v, input pin_t s);
    return (v << s) | (v >> (6'd32 - {1'b0, s}));
  endfunction

  function automatic word_t rotr(input word_t v, input pin_t s);
    return (v >> s) | (v << (6'd32 - {1'b0, s}));
  endfunction

  div_t        div_cnt;
  logic        en_q;
  logic        tick;
  logic        go;
  instr_t      cur;
  opcode_t     op;
  logic [2:0]  sel;
  logic [4:0]  imm5;
  logic [5:0]  nbits;
  logic        jmp_take;
  logic        stall;
  addr_t       pc_next;
  word_t       x, isr, osr;
  word_t       pin_val, pin_dir;
  word_t       out_win, set_win;
  word_t       in_src, in_aligned, out_data, set_data;
  logic [63:0] in_shift;

  assign tick = en && en_q && (div_cnt >= cfg.clk_div);
  assign go   = exec || tick;
  assign cur  = exec ? exec_instr : instr;  // Host exec overrides fetch
  assign op   = opcode_t'(cur[15:13]);
  assign sel  = cur[7:5];
  assign imm5 = cur[4:0];
  assign nbits = (imm5 == 5'd0) ? FULL_COUNT : {1'b0, imm5};

  assign jmp_take = op == OP_JMP &&
                    (sel == JMP_ALWAYS ||
                     (sel == JMP_X_ZERO && x == '0) ||
                     (sel == JMP_X_DEC && x != '0));
  assign stall   = op == OP_PUSHPULL && (cur[7] ? tx_empty : rx_full);
  assign tx_pop  = go && op == OP_PUSHPULL && cur[7] && !tx_empty;
  assign rx_push = go && op == OP_PUSHPULL && !cur[7] && !rx_full;
  assign rx_data = isr;
  assign pc_next = (pc == cfg.wrap_top) ? cfg.wrap_bottom : pc + 1'b1;

  assign out_win = rotl(low_mask({3'b0, cfg.out_count}), cfg.out_base);
  assign set_win = rotl(low_mask({3'b0, cfg.set_count}), cfg.set_base);

  // IN shifts the low nbits of the source in from the right
  assign in_src     = (sel == IN_SRC_PINS) ? rotr(gpio_in, cfg.in_base) : x;
  assign in_aligned = in_src << (FULL_COUNT - nbits);
  assign in_shift   = {isr, in_aligned} << nbits;

  assign out_data = rotl(osr & low_mask(nbits), cfg.out_base);
  assign set_data = rotl(word_t'(imm5), cfg.set_base);

  assign pins = '{values: pin_val, dirs: pin_dir, owned: out_win | set_win};

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      en_q    <= 1'b0;
      pc      <= '0;
      x       <= '0;
      isr     <= '0;
      osr     <= '0;
      pin_val <= '0;
      pin_dir <= '0;
    end else begin
      en_q <= en;
      if (!en || !en_q || tick) div_cnt <= '0;
      else div_cnt <= div_cnt + 1'b1;

      if (go) begin
        case (op)
          OP_JMP: if (sel == JMP_X_DEC) x <= x - 1'b1;  // Decrements even at zero
          OP_IN: isr <= in_shift[63:32];
          OP_OUT: begin
            pin_val <= (pin_val & ~out_win) | (out_data & out_win);
            osr     <= osr >> nbits;
          end
          OP_PUSHPULL: begin
            if (cur[7]) begin
              if (!tx_empty) osr <= tx_data;
            end else if (!rx_full) begin
              isr <= '0;
            end
          end
          OP_SET: begin
            case (sel)
              SET_PINS:    pin_val <= (pin_val & ~set_win) | (set_data & set_win);
              SET_X:       x <= word_t'(imm5);
              SET_PINDIRS: pin_dir <= (pin_dir & ~set_win) | (set_data & set_win);
              default: ;
            endcase
          end
          default: ;
        endcase
      end

      if (en && !en_q) pc <= cfg.wrap_bottom;
      else if (go && jmp_take) pc <= imm5;
      else if (tick && !exec && !stall) pc <= pc_next;  // Stall retries same PC
    end
  end

endmodule

`default_nettype wire

//--- verilog/pio_gpio_combine.sv
`timescale 1ns/1ps
`default_nettype none

module pio_gpio_combine import pio_pkg::*; #(
  parameter int NUM_SM = 4
) (
  input  wire sm_pins_t pins [NUM_SM],
  output word_t         gpio_out,
  output word_t         gpio_dir
);

  // Later machines overwrite earlier ones on owned pins
  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int m = 0; m < NUM_SM; m++) begin
      gpio_out = (gpio_out & ~pins[m].owned) | (pins[m].values & pins[m].owned);
      gpio_dir = (gpio_dir & ~pins[m].owned) | (pins[m].dirs & pins[m].owned);
    end
  end

endmodule

`default_nettype wire

//--- pio/pio.sv
`timescale 1ns/1ps
`default_nettype none

module pio import pio_pkg::*; #(
  parameter int NUM_SM     = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  wire              clk,
  input  wire              reset,
  input  wire sm_idx_t     mindex,
  input  wire addr_t       index,
  input  wire action_t     action,
  input  wire word_t       din,
  input  wire word_t       gpio_in,
  output word_t            dout,
  output word_t            gpio_out,
  output word_t            gpio_dir,
  output logic [NUM_SM-1:0] tx_full,
  output logic [NUM_SM-1:0] rx_empty
);

  instr_t     imem [IMEM_DEPTH];
  sm_config_t cfg [NUM_SM];
  logic [NUM_SM-1:0] en;

  addr_t    pc [NUM_SM];
  word_t    tx_rdata [NUM_SM];
  word_t    rx_wdata [NUM_SM];
  word_t    rx_rdata [NUM_SM];
  sm_pins_t sm_pins [NUM_SM];
  logic [NUM_SM-1:0] tx_empty, tx_pop, tx_push;
  logic [NUM_SM-1:0] rx_full, rx_push, rx_pop, exec;
  logic              mindex_ok;

  assign mindex_ok = int'(mindex) < NUM_SM;

  // Shared program store, no reset
  always_ff @(posedge clk) begin
    if (action == ACT_WRITE_INSTR) imem[index] <= din[15:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en <= '0;
      for (int i = 0; i < NUM_SM; i++) cfg[i] <= '0;
    end else begin
      case (action)
        ACT_SET_WRAP: if (mindex_ok) begin
          cfg[mindex].wrap_top    <= index;
          cfg[mindex].wrap_bottom <= din[4:0];
        end
        ACT_PIN_CONFIG: if (mindex_ok) begin
          cfg[mindex].set_count <= din[2:0];
          cfg[mindex].set_base  <= din[7:3];
          cfg[mindex].out_count <= din[10:8];
          cfg[mindex].out_base  <= din[15:11];
          cfg[mindex].in_base   <= din[20:16];
        end
        ACT_ENABLE: en <= din[NUM_SM-1:0];
        ACT_CLKDIV: if (mindex_ok) cfg[mindex].clk_div <= din[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) dout <= '0;
    else if (action == ACT_RX_POP && mindex_ok && !rx_empty[mindex])
      dout <= rx_rdata[mindex];
  end

  for (genvar j = 0; j < NUM_SM; j++) begin : g_sm
    assign tx_push[j] = action == ACT_TX_PUSH && mindex == sm_idx_t'(j);
    assign rx_pop[j]  = action == ACT_RX_POP && mindex == sm_idx_t'(j);
    assign exec[j]    = action == ACT_EXEC && mindex == sm_idx_t'(j);

    pio_machine u_machine (
      .clk(clk), .reset(reset), .en(en[j]),
      .exec(exec[j]), .exec_instr(din[15:0]), .instr(imem[pc[j]]),
      .cfg(cfg[j]), .gpio_in(gpio_in),
      .tx_data(tx_rdata[j]), .tx_empty(tx_empty[j]), .rx_full(rx_full[j]),
      .pc(pc[j]), .tx_pop(tx_pop[j]), .rx_push(rx_push[j]),
      .rx_data(rx_wdata[j]), .pins(sm_pins[j])
    );

    pio_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
      .clk(clk), .reset(reset), .push(tx_push[j]), .pop(tx_pop[j]),
      .wdata(din), .rdata(tx_rdata[j]), .full(tx_full[j]), .empty(tx_empty[j])
    );

    pio_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .clk(clk), .reset(reset), .push(rx_push[j]), .pop(rx_pop[j]),
      .wdata(rx_wdata[j]), .rdata(rx_rdata[j]), .full(rx_full[j]), .empty(rx_empty[j])
    );
  end

  pio_gpio_combine #(.NUM_SM(NUM_SM)) u_combine (
    .pins(sm_pins),
    .gpio_out(gpio_out),
    .gpio_dir(gpio_dir)
  );

endmodule

`default_nettype wire

//--- sim/pio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pio_tb import pio_pkg::*; ();

  localparam int NUM_SM      = 4;
  localparam int FIFO_DEPTH  = 4;
  localparam int TABLE_LEN   = 12;
  localparam int WAIT_LIMIT  = 400;
  localparam int WATCHDOG_NS = TABLE_LEN * 2000 + 5000;

  localparam logic [2:0] K_PIN  = 3'd0;
  localparam logic [2:0] K_DATA = 3'd1;
  localparam logic [2:0] K_LOOP = 3'd2;
  localparam logic [2:0] K_BP   = 3'd3;
  localparam logic [2:0] K_PRIO = 3'd4;

  typedef struct packed {
    logic [2:0] kind;
    div_t       div;
    count_t     cnt;       // Set or out window width
    pin_t       base;
    pin_t       inb;
    logic [4:0] val;       // SET data or loop count
    word_t      tx;
    word_t      gin;
    word_t      exp_gpio;
    word_t      exp_dir;
    word_t      exp_rx;
  } entry_t;

  logic              clk = 1'b0;
  logic              reset;
  sm_idx_t           mindex;
  addr_t             index;
  action_t           action;
  word_t             din;
  word_t             gpio_in = '0;
  word_t             dout, gpio_out, gpio_dir;
  logic [NUM_SM-1:0] tx_full, rx_empty;
  logic              loopback = 1'b0;
  word_t             gin_value = '0;
  int                errors = 0;
  entry_t            tbl [TABLE_LEN];

  pio #(.NUM_SM(NUM_SM), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk(clk), .reset(reset), .mindex(mindex), .index(index), .action(action),
    .din(din), .gpio_in(gpio_in), .dout(dout), .gpio_out(gpio_out),
    .gpio_dir(gpio_dir), .tx_full(tx_full), .rx_empty(rx_empty)
  );

  always #5 clk = ~clk;

  always @(negedge clk) gpio_in <= loopback ? gpio_out : gin_value;  // Pins fed back

  function automatic word_t place_field(input word_t v, input pin_t base, input count_t n);
    return (v & ((32'd1 << n) - 32'd1)) << base;
  endfunction

  function automatic instr_t encode(input opcode_t op, input logic [2:0] sel,
                                    input logic [4:0] imm);
    return {op, 5'd0, sel, imm};
  endfunction

  function automatic word_t pin_config_word(input pin_t ib, input pin_t ob, input count_t oc,
                                            input pin_t sb, input count_t sc);
    return {11'd0, ib, ob, oc, sb, sc};
  endfunction

  function automatic entry_t make_entry(input logic [2:0] kind, input div_t div,
                                        input count_t cnt, input pin_t base,
                                        input pin_t inb, input logic [4:0] val);
    entry_t e;
    e = '0;
    e.kind = kind;
    e.div = div;
    e.cnt = cnt;
    e.base = base;
    e.inb = inb;
    e.val = val;
    e.tx = $urandom();
    e.gin = $urandom();
    e.exp_dir = place_field('1, base, cnt);
    case (kind)
      K_PIN: e.exp_gpio = place_field(word_t'(val), base, cnt);
      K_DATA: begin
        e.exp_gpio = place_field(e.tx, base, cnt);
        e.exp_rx = place_field(e.gin >> inb, '0, cnt);
      end
      K_LOOP: e.exp_rx = '1;  // X ends one below zero
      default: ;
    endcase
    return e;
  endfunction

  task automatic build_table();
    tbl[0] = make_entry(K_PIN, 16'd0, 3'd5, 5'd3, 5'd0, 5'h16);
    tbl[1] = make_entry(K_PIN, 16'd2, 3'd3, 5'd20, 5'd0, 5'h1d);
    tbl[2] = make_entry(K_DATA, 16'd0, 3'd7, 5'd10, 5'd5, 5'd0);
    tbl[3] = make_entry(K_DATA, 16'd0, 3'd4, 5'd0, 5'd24, 5'd0);
    tbl[4] = make_entry(K_DATA, 16'd0, 3'd1, 5'd31, 5'd0, 5'd0);
    for (int i = 2; i < 5; i++) begin
      tbl[i + 3] = tbl[i];
      tbl[i + 3].div = 16'd3;  // Slower divider with inverted word
      tbl[i + 3].tx = ~tbl[i].tx;
      tbl[i + 3].exp_gpio = place_field(tbl[i + 3].tx, tbl[i].base, tbl[i].cnt);
    end
    tbl[8] = make_entry(K_LOOP, 16'd0, 3'd0, 5'd0, 5'd0, 5'd6);
    tbl[9] = make_entry(K_LOOP, 16'd1, 3'd0, 5'd0, 5'd0, 5'd0);
    tbl[10] = make_entry(K_BP, 16'd0, 3'd7, 5'd8, 5'd8, 5'd0);
    tbl[11] = make_entry(K_PRIO, 16'd0, 3'd0, 5'd0, 5'd0, 5'h15);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input string what, input logic [NUM_SM-1:0] got,
                             input logic [NUM_SM-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic host_action(input action_t a, input sm_idx_t m, input addr_t i,
                             input word_t d);
    @(negedge clk);
    action = a;
    mindex = m;
    index = i;
    din = d;
    @(negedge clk);
    action = ACT_NOP;
  endtask

  task automatic write_instr(input addr_t a, input instr_t w);
    host_action(ACT_WRITE_INSTR, '0, a, word_t'(w));
  endtask

  task automatic load_programs();
    write_instr(5'd0, encode(OP_SET, SET_PINDIRS, 5'h1f));
    write_instr(5'd2, encode(OP_PUSHPULL, 3'd0, 5'd0));
    write_instr(5'd3, encode(OP_JMP, JMP_ALWAYS, 5'd3));
    write_instr(5'd4, encode(OP_PUSHPULL, 3'b100, 5'd0));  // PULL
    write_instr(5'd7, encode(OP_PUSHPULL, 3'd0, 5'd0));
    write_instr(5'd9, encode(OP_JMP, JMP_X_DEC, 5'd9));
    write_instr(5'd10, encode(OP_IN, 3'd1, 5'd0));  // All 32 bits of X
    write_instr(5'd11, encode(OP_PUSHPULL, 3'd0, 5'd0));
    write_instr(5'd12, encode(OP_JMP, JMP_ALWAYS, 5'd12));
  endtask

  task automatic write_io(input count_t n);
    write_instr(5'd5, encode(OP_OUT, 3'd0, 5'(n)));
    write_instr(5'd6, encode(OP_IN, IN_SRC_PINS, 5'(n)));
  endtask

  task automatic setup_sm(input sm_idx_t m, input addr_t bottom, input addr_t top,
                          input word_t pins, input div_t div);
    host_action(ACT_ENABLE, '0, '0, '0);
    host_action(ACT_SET_WRAP, m, top, word_t'(bottom));
    host_action(ACT_PIN_CONFIG, m, '0, pins);
    host_action(ACT_CLKDIV, m, '0, word_t'(div));
  endtask

  task automatic wait_rx(input sm_idx_t m);
    int k;
    k = 0;
    while (rx_empty[m] && k < WAIT_LIMIT) begin
      @(negedge clk);
      k++;
    end
    if (rx_empty[m]) begin
      errors++;
      $display("timeout at %0t ns: machine %0d pushed no RX data", $time, m);
    end
  endtask

  task automatic wait_gpio(input word_t v);
    int k;
    k = 0;
    while (gpio_out !== v && k < WAIT_LIMIT) begin
      @(negedge clk);
      k++;
    end
    if (gpio_out !== v) begin
      errors++;
      $display("timeout at %0t ns: gpio_out never reached %h", $time, v);
    end
  endtask

  task automatic pop_check(input sm_idx_t m, input word_t exp, input string what);
    wait_rx(m);
    host_action(ACT_RX_POP, m, '0, '0);
    check_word(what, dout, exp);
  endtask

  task automatic backpressure_test(input entry_t e);
    word_t words [FIFO_DEPTH+2];
    loopback = 1'b1;
    setup_sm(2'd0, 5'd4, 5'd7, pin_config_word(e.base, e.base, e.cnt, '0, '0), e.div);
    write_io(e.cnt);
    host_action(ACT_ENABLE, '0, '0, 32'd1);
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      words[i] = ($urandom() & ~32'h7f) | word_t'(i * 19 + 5);  // Distinct low bits
      host_action(ACT_TX_PUSH, '0, '0, words[i]);
    end
    // Last word to reach the pins before RX backs up
    wait_gpio(place_field(words[FIFO_DEPTH], e.base, e.cnt));
    check_flags("tx_full during stall", tx_full, '0);
    check_flags("rx_empty during stall", rx_empty, ~NUM_SM'(1));
    for (int i = 0; i < FIFO_DEPTH + 2; i++)
      pop_check(2'd0, place_field(words[i], '0, e.cnt), "rx word after stall");
    loopback = 1'b0;
  endtask

  task automatic priority_test(input entry_t e);
    word_t      w1, w2;
    logic [4:0] v2;
    w1 = place_field('1, 5'd4, 3'd5);
    w2 = place_field('1, 5'd6, 3'd4);
    v2 = ~e.val;
    host_action(ACT_ENABLE, '0, '0, '0);
    host_action(ACT_PIN_CONFIG, 2'd0, '0, '0);
    host_action(ACT_PIN_CONFIG, 2'd1, '0, pin_config_word('0, '0, '0, 5'd4, 3'd5));
    host_action(ACT_PIN_CONFIG, 2'd2, '0, pin_config_word('0, '0, '0, 5'd6, 3'd4));
    host_action(ACT_EXEC, 2'd1, '0, word_t'(encode(OP_SET, SET_PINDIRS, 5'h1f)));
    host_action(ACT_EXEC, 2'd1, '0, word_t'(encode(OP_SET, SET_PINS, e.val)));
    host_action(ACT_EXEC, 2'd2, '0, word_t'(encode(OP_SET, SET_PINDIRS, 5'h1f)));
    host_action(ACT_EXEC, 2'd2, '0, word_t'(encode(OP_SET, SET_PINS, v2)));
    check_word("gpio_out with overlap", gpio_out,
               (place_field(word_t'(e.val), 5'd4, 3'd5) & ~w2) |
               place_field(word_t'(v2), 5'd6, 3'd4));
    check_word("gpio_dir with overlap", gpio_dir, w1 | w2);
  endtask

  task automatic apply_entry(input entry_t e);
    case (e.kind)
      K_PIN: begin
        setup_sm(2'd0, 5'd0, 5'd3, pin_config_word('0, '0, '0, e.base, e.cnt), e.div);
        write_instr(5'd1, encode(OP_SET, SET_PINS, e.val));
        host_action(ACT_ENABLE, '0, '0, 32'd1);
        wait_rx(2'd0);
        check_word("gpio_out after SET", gpio_out, e.exp_gpio);
        check_word("gpio_dir after SET", gpio_dir, e.exp_dir);
        pop_check(2'd0, '0, "ISR pushed by pin program");
      end
      K_DATA: begin
        gin_value = e.gin;
        setup_sm(2'd0, 5'd4, 5'd7, pin_config_word(e.inb, e.base, e.cnt, '0, '0), e.div);
        write_io(e.cnt);
        host_action(ACT_ENABLE, '0, '0, 32'd1);
        host_action(ACT_TX_PUSH, '0, '0, e.tx);
        wait_rx(2'd0);
        check_word("gpio_out after OUT", gpio_out, e.exp_gpio);
        pop_check(2'd0, e.exp_rx, "rx word from IN pins");
      end
      K_LOOP: begin
        setup_sm(2'd0, 5'd8, 5'd12, '0, e.div);
        write_instr(5'd8, encode(OP_SET, SET_X, e.val));
        host_action(ACT_ENABLE, '0, '0, 32'd1);
        pop_check(2'd0, e.exp_rx, "X after countdown");
      end
      K_BP: backpressure_test(e);
      default: priority_test(e);
    endcase
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hdc14_325f));
    reset = 1'b1;
    action = ACT_NOP;
    mindex = '0;
    index = '0;
    din = '0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_word("gpio_out after reset", gpio_out, '0);
    check_word("gpio_dir after reset", gpio_dir, '0);
    check_flags("rx_empty after reset", rx_empty, '1);
    check_flags("tx_full after reset", tx_full, '0);
    load_programs();
    foreach (tbl[i]) apply_entry(tbl[i]);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/pio_pkg.sv
pio/pio_fifo.sv
pio/pio_machine.sv
verilog/pio_gpio_combine.sv
pio/pio.sv
sim/pio_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module pio_tb -f verilog.f -o pio_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pio_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
